//--- hdl/traffic_pkg.sv
package traffic_pkg;

	// width of the encoded phase register
	localparam int phase_width = 4;

	// width of the phase down-counter, wide enough for the 60 cycle greens
	localparam int timer_width = 6;

	// east/west half of the cycle
	// pedestrian path runs walk, flash, dont_walk and then joins at amber
	localparam logic [phase_width-1:0] ph_ew_walk      = 4'd0;
	localparam logic [phase_width-1:0] ph_ew_flash     = 4'd1;
	localparam logic [phase_width-1:0] ph_ew_dont_walk = 4'd2;
	localparam logic [phase_width-1:0] ph_ew_green     = 4'd3;
	localparam logic [phase_width-1:0] ph_ew_amber     = 4'd4;
	localparam logic [phase_width-1:0] ph_all_red_a    = 4'd5;

	// protected southbound left arrow, only on request
	localparam logic [phase_width-1:0] ph_sb_left      = 4'd6;

	// north/south half of the cycle
	localparam logic [phase_width-1:0] ph_ns_walk      = 4'd7;
	localparam logic [phase_width-1:0] ph_ns_flash     = 4'd8;
	localparam logic [phase_width-1:0] ph_ns_dont_walk = 4'd9;
	localparam logic [phase_width-1:0] ph_ns_green     = 4'd10;
	localparam logic [phase_width-1:0] ph_ns_amber     = 4'd11;
	localparam logic [phase_width-1:0] ph_all_red_b    = 4'd12;

	// phase durations in clock cycles
	// walk + flash + dont_walk equals one plain green, so both paths take 60
	localparam logic [timer_width-1:0] dur_walk      = 6'd10;
	localparam logic [timer_width-1:0] dur_flash     = 6'd20;
	localparam logic [timer_width-1:0] dur_dont_walk = 6'd30;
	localparam logic [timer_width-1:0] dur_green     = 6'd60;
	localparam logic [timer_width-1:0] dur_amber     = 6'd6;
	localparam logic [timer_width-1:0] dur_all_red   = 6'd2;

	// left arrow has its own name even though it matches the flash time
	localparam logic [timer_width-1:0] dur_left      = 6'd20;

	// controller wakes up with east/west green and the full green time loaded
	localparam logic [phase_width-1:0] reset_phase   = ph_ew_green;

endpackage

//--- hdl/phase_timer.sv
`timescale 1ns/1ps

module phase_timer (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [traffic_pkg::phase_width-1:0] next_phase,
	output logic                              expired
);

	import traffic_pkg::*;

	// remaining cycles of the current phase, counts down to 1
	logic [timer_width-1:0] count;

	// duration lookup for any phase code
	function automatic logic [timer_width-1:0] phase_duration(
		input logic [phase_width-1:0] ph
	);
		case (ph)
			ph_ew_walk, ph_ns_walk:           phase_duration = dur_walk;
			ph_ew_flash, ph_ns_flash:         phase_duration = dur_flash;
			ph_ew_dont_walk, ph_ns_dont_walk: phase_duration = dur_dont_walk;
			ph_ew_green, ph_ns_green:         phase_duration = dur_green;
			ph_ew_amber, ph_ns_amber:         phase_duration = dur_amber;
			ph_all_red_a, ph_all_red_b:       phase_duration = dur_all_red;
			ph_sb_left:                       phase_duration = dur_left;
			// unused codes fall back to the reset phase time
			default:                          phase_duration = dur_green;
		endcase
	endfunction

	// last cycle of the phase, the sequencer moves on at the next edge
	assign expired = (count == timer_width'(1));

	// reload with the upcoming phase's time on expiry, else count down
	// entering at D and leaving at 1 gives exactly D cycles per phase
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= phase_duration(reset_phase);
		end else if (expired) begin
			count <= phase_duration(next_phase);
		end else begin
			count <= count - timer_width'(1);
		end
	end

endmodule

//--- hdl/phase_sequencer.sv
`timescale 1ns/1ps

module phase_sequencer (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                expired,
	input  logic                                walk_request,
	input  logic                                southbound_left_request,
	output logic [traffic_pkg::phase_width-1:0] phase,
	output logic [traffic_pkg::phase_width-1:0] next_phase
);

	import traffic_pkg::*;

	// pending requests, held until the serving phase is entered
	logic walk_flag;
	logic left_flag;

	// phase transitions that serve a pending request
	logic enter_walk;
	logic enter_left;

	// next phase choice
	// always formed from the current phase, only taken when the timer expires
	always_comb begin
		case (phase)
			// east/west pedestrian path
			ph_ew_walk:      next_phase = ph_ew_flash;
			ph_ew_flash:     next_phase = ph_ew_dont_walk;
			ph_ew_dont_walk: next_phase = ph_ew_amber;
			ph_ew_green:     next_phase = ph_ew_amber;
			ph_ew_amber:     next_phase = ph_all_red_a;

			// left arrow has priority over the north/south walk
			ph_all_red_a: begin
				if (left_flag) begin
					next_phase = ph_sb_left;
				end else if (walk_flag) begin
					next_phase = ph_ns_walk;
				end else begin
					next_phase = ph_ns_green;
				end
			end

			ph_sb_left: begin
				if (walk_flag) begin
					next_phase = ph_ns_walk;
				end else begin
					next_phase = ph_ns_green;
				end
			end

			// north/south pedestrian path
			ph_ns_walk:      next_phase = ph_ns_flash;
			ph_ns_flash:     next_phase = ph_ns_dont_walk;
			ph_ns_dont_walk: next_phase = ph_ns_amber;
			ph_ns_green:     next_phase = ph_ns_amber;
			ph_ns_amber:     next_phase = ph_all_red_b;

			// back to east/west, with the walk path if someone is waiting
			ph_all_red_b: begin
				if (walk_flag) begin
					next_phase = ph_ew_walk;
				end else begin
					next_phase = ph_ew_green;
				end
			end

			// unused codes recover to the start of the cycle
			default:         next_phase = reset_phase;
		endcase
	end

	// edges that enter a serving phase
	assign enter_walk = expired && ((next_phase == ph_ew_walk) || (next_phase == ph_ns_walk));
	assign enter_left = expired && (next_phase == ph_sb_left);

	// phase register, advances only on the last cycle of a phase
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= reset_phase;
		end else if (expired) begin
			phase <= next_phase;
		end
	end

	// request flags
	// a request on the clearing edge wins so it is not lost
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			walk_flag <= 1'b0;
			left_flag <= 1'b0;
		end else begin
			walk_flag <= walk_request || (walk_flag && !enter_walk);
			left_flag <= southbound_left_request || (left_flag && !enter_left);
		end
	end

endmodule

//--- hdl/signal_decoder.sv
`timescale 1ns/1ps

module signal_decoder (
	input  logic [traffic_pkg::phase_width-1:0] phase,

	output logic northbound_green,
	output logic northbound_amber,
	output logic northbound_red,
	output logic northbound_walk,
	output logic northbound_flashing_dont_walk,
	output logic northbound_dont_walk,

	output logic southbound_green,
	output logic southbound_amber,
	output logic southbound_red,
	output logic southbound_left,
	output logic southbound_walk,
	output logic southbound_flashing_dont_walk,
	output logic southbound_dont_walk,

	output logic eastbound_green,
	output logic eastbound_amber,
	output logic eastbound_red,
	output logic eastbound_walk,
	output logic eastbound_flashing_dont_walk,
	output logic eastbound_dont_walk,

	output logic westbound_green,
	output logic westbound_amber,
	output logic westbound_red,
	output logic westbound_walk,
	output logic westbound_flashing_dont_walk,
	output logic westbound_dont_walk
);

	import traffic_pkg::*;

	// shared lamp terms, each pair of opposing approaches shows the same aspect
	logic ew_green;
	logic ew_amber;
	logic ew_walk;
	logic ew_flash;
	logic ns_green;
	logic ns_amber;
	logic ns_walk;
	logic ns_flash;
	logic left_arrow;

	// vehicles keep green through the whole pedestrian path
	assign ew_green = (phase == ph_ew_walk) || (phase == ph_ew_flash) ||
		(phase == ph_ew_dont_walk) || (phase == ph_ew_green);
	assign ew_amber = (phase == ph_ew_amber);
	assign ew_walk  = (phase == ph_ew_walk);
	assign ew_flash = (phase == ph_ew_flash);

	assign ns_green = (phase == ph_ns_walk) || (phase == ph_ns_flash) ||
		(phase == ph_ns_dont_walk) || (phase == ph_ns_green);
	assign ns_amber = (phase == ph_ns_amber);
	assign ns_walk  = (phase == ph_ns_walk);
	assign ns_flash = (phase == ph_ns_flash);

	assign left_arrow = (phase == ph_sb_left);

	// east/west vehicle and pedestrian lamps
	assign eastbound_green              = ew_green;
	assign eastbound_amber              = ew_amber;
	assign eastbound_red                = !(ew_green || ew_amber);
	assign eastbound_walk               = ew_walk;
	assign eastbound_flashing_dont_walk = ew_flash;
	assign eastbound_dont_walk          = !(ew_walk || ew_flash);

	assign westbound_green              = ew_green;
	assign westbound_amber              = ew_amber;
	assign westbound_red                = !(ew_green || ew_amber);
	assign westbound_walk               = ew_walk;
	assign westbound_flashing_dont_walk = ew_flash;
	assign westbound_dont_walk          = !(ew_walk || ew_flash);

	// north/south lamps, northbound holds red during the left arrow
	assign northbound_green              = ns_green;
	assign northbound_amber              = ns_amber;
	assign northbound_red                = !(ns_green || ns_amber);
	assign northbound_walk               = ns_walk;
	assign northbound_flashing_dont_walk = ns_flash;
	assign northbound_dont_walk          = !(ns_walk || ns_flash);

	// southbound arrow replaces southbound red while it is lit
	assign southbound_green              = ns_green;
	assign southbound_amber              = ns_amber;
	assign southbound_red                = !(ns_green || ns_amber || left_arrow);
	assign southbound_left               = left_arrow;
	assign southbound_walk               = ns_walk;
	assign southbound_flashing_dont_walk = ns_flash;
	assign southbound_dont_walk          = !(ns_walk || ns_flash);

endmodule

//--- hdl/traffic_signal_controller.sv
`timescale 1ns/1ps

module traffic_signal_controller (
	input  logic clk,
	input  logic reset,
	input  logic walk_request,
	input  logic southbound_left_request,

	output logic northbound_green,
	output logic northbound_amber,
	output logic northbound_red,
	output logic northbound_walk,
	output logic northbound_flashing_dont_walk,
	output logic northbound_dont_walk,

	output logic southbound_green,
	output logic southbound_amber,
	output logic southbound_red,
	output logic southbound_left,
	output logic southbound_walk,
	output logic southbound_flashing_dont_walk,
	output logic southbound_dont_walk,

	output logic eastbound_green,
	output logic eastbound_amber,
	output logic eastbound_red,
	output logic eastbound_walk,
	output logic eastbound_flashing_dont_walk,
	output logic eastbound_dont_walk,

	output logic westbound_green,
	output logic westbound_amber,
	output logic westbound_red,
	output logic westbound_walk,
	output logic westbound_flashing_dont_walk,
	output logic westbound_dont_walk
);

	import traffic_pkg::*;

	// current and upcoming phase from the sequencer
	logic [phase_width-1:0] phase;
	logic [phase_width-1:0] next_phase;
	// last cycle of the current phase
	logic                   expired;

	// times each phase and reloads with the next phase's duration
	phase_timer i_timer (
		.clk        (clk),
		.reset      (reset),
		.next_phase (next_phase),
		.expired    (expired)
	);

	// phase register and request flags
	phase_sequencer i_sequencer (
		.clk                     (clk),
		.reset                   (reset),
		.expired                 (expired),
		.walk_request            (walk_request),
		.southbound_left_request (southbound_left_request),
		.phase                   (phase),
		.next_phase              (next_phase)
	);

	// lamps follow the phase combinationally
	signal_decoder i_decoder (
		.phase                         (phase),
		.northbound_green              (northbound_green),
		.northbound_amber              (northbound_amber),
		.northbound_red                (northbound_red),
		.northbound_walk               (northbound_walk),
		.northbound_flashing_dont_walk (northbound_flashing_dont_walk),
		.northbound_dont_walk          (northbound_dont_walk),
		.southbound_green              (southbound_green),
		.southbound_amber              (southbound_amber),
		.southbound_red                (southbound_red),
		.southbound_left               (southbound_left),
		.southbound_walk               (southbound_walk),
		.southbound_flashing_dont_walk (southbound_flashing_dont_walk),
		.southbound_dont_walk          (southbound_dont_walk),
		.eastbound_green               (eastbound_green),
		.eastbound_amber               (eastbound_amber),
		.eastbound_red                 (eastbound_red),
		.eastbound_walk                (eastbound_walk),
		.eastbound_flashing_dont_walk  (eastbound_flashing_dont_walk),
		.eastbound_dont_walk           (eastbound_dont_walk),
		.westbound_green               (westbound_green),
		.westbound_amber               (westbound_amber),
		.westbound_red                 (westbound_red),
		.westbound_walk                (westbound_walk),
		.westbound_flashing_dont_walk  (westbound_flashing_dont_walk),
		.westbound_dont_walk           (westbound_dont_walk)
	);

endmodule

//--- verif/traffic_chk.sv
`timescale 1ns/1ps

// lamp safety properties, attached to the controller top level
module traffic_chk (
	input logic clk,
	input logic reset,
	input logic northbound_green, northbound_amber, northbound_red, northbound_walk,
	input logic southbound_green, southbound_amber, southbound_red, southbound_left,
	input logic southbound_walk,
	input logic eastbound_green, eastbound_amber, eastbound_red, eastbound_walk,
	input logic westbound_green, westbound_amber, westbound_red, westbound_walk
);

	// every approach shows exactly one vehicle aspect
	nb_one_aspect: assert property (@(posedge clk) disable iff (reset)
		$onehot({northbound_green, northbound_amber, northbound_red}))
		else $error("northbound shows no single aspect");
	// southbound counts its left arrow in place of red
	sb_one_aspect: assert property (@(posedge clk) disable iff (reset)
		$onehot({southbound_green, southbound_amber, southbound_red, southbound_left}))
		else $error("southbound shows no single aspect");
	eb_one_aspect: assert property (@(posedge clk) disable iff (reset)
		$onehot({eastbound_green, eastbound_amber, eastbound_red}))
		else $error("eastbound shows no single aspect");
	wb_one_aspect: assert property (@(posedge clk) disable iff (reset)
		$onehot({westbound_green, westbound_amber, westbound_red}))
		else $error("westbound shows no single aspect");

	// crossing streams are never released together
	no_conflict: assert property (@(posedge clk) disable iff (reset)
		!((eastbound_green || eastbound_amber || westbound_green || westbound_amber) &&
		(northbound_green || northbound_amber || southbound_green || southbound_amber)))
		else $error("east/west and north/south released together");

	// pedestrians only walk beside moving traffic of the same axis
	ew_walk_on_green: assert property (@(posedge clk) disable iff (reset)
		(!eastbound_walk || eastbound_green) && (!westbound_walk || westbound_green))
		else $error("east/west walk lit without green");
	ns_walk_on_green: assert property (@(posedge clk) disable iff (reset)
		(!northbound_walk || northbound_green) && (!southbound_walk || southbound_green))
		else $error("north/south walk lit without green");

endmodule

// one checker per controller instance
bind traffic_signal_controller traffic_chk i_chk (.*);

//--- verif/traffic_tb.sv
`timescale 1ns/1ps

module traffic_tb;

	import traffic_pkg::*;

	// five full 156 cycle rounds per directed test plus the random run
	localparam int cycle_limit = 5 * 5 * 156 + 3000;

	// lamp selectors for duration measurements
	localparam int sel_ew_green = 0;
	localparam int sel_ew_amber = 1;
	localparam int sel_all_red  = 2;
	localparam int sel_ns_green = 3;
	localparam int sel_ns_amber = 4;
	localparam int sel_ew_walk  = 5;
	localparam int sel_ew_flash = 6;
	localparam int sel_ns_walk  = 7;
	localparam int sel_ns_flash = 8;
	localparam int sel_left     = 9;

	logic clk;
	logic reset;
	logic walk_request;
	logic southbound_left_request;
	logic northbound_green, northbound_amber, northbound_red;
	logic northbound_walk, northbound_flashing_dont_walk, northbound_dont_walk;
	logic southbound_green, southbound_amber, southbound_red, southbound_left;
	logic southbound_walk, southbound_flashing_dont_walk, southbound_dont_walk;
	logic eastbound_green, eastbound_amber, eastbound_red;
	logic eastbound_walk, eastbound_flashing_dont_walk, eastbound_dont_walk;
	logic westbound_green, westbound_amber, westbound_red;
	logic westbound_walk, westbound_flashing_dont_walk, westbound_dont_walk;

	// reference model state
	logic [phase_width-1:0] m_phase;
	logic [phase_width-1:0] m_next;
	int                     m_count;
	logic                   m_walk;
	logic                   m_left;

	int          cycles;
	int          test_checks;
	int          test_errors;
	int          lamp_checks;
	int          lamp_errors;
	logic [31:0] lfsr;

	traffic_signal_controller i_dut (.*);

	// lamps as seen from the DUT, grouped per approach
	wire [5:0] nb_act = {northbound_green, northbound_amber, northbound_red,
		northbound_walk, northbound_flashing_dont_walk, northbound_dont_walk};
	wire [6:0] sb_act = {southbound_green, southbound_amber, southbound_red, southbound_left,
		southbound_walk, southbound_flashing_dont_walk, southbound_dont_walk};
	wire [5:0] eb_act = {eastbound_green, eastbound_amber, eastbound_red,
		eastbound_walk, eastbound_flashing_dont_walk, eastbound_dont_walk};
	wire [5:0] wb_act = {westbound_green, westbound_amber, westbound_red,
		westbound_walk, westbound_flashing_dont_walk, westbound_dont_walk};

	// sequence rule, left arrow ahead of the north/south walk
	function automatic logic [phase_width-1:0] model_next(
		input logic [phase_width-1:0] ph, input logic w, input logic l);
		case (ph)
			ph_ew_walk:                   model_next = ph_ew_flash;
			ph_ew_flash:                  model_next = ph_ew_dont_walk;
			ph_ew_dont_walk, ph_ew_green: model_next = ph_ew_amber;
			ph_ew_amber:                  model_next = ph_all_red_a;
			ph_all_red_a:                 model_next = l ? ph_sb_left : (w ? ph_ns_walk : ph_ns_green);
			ph_sb_left:                   model_next = w ? ph_ns_walk : ph_ns_green;
			ph_ns_walk:                   model_next = ph_ns_flash;
			ph_ns_flash:                  model_next = ph_ns_dont_walk;
			ph_ns_dont_walk, ph_ns_green: model_next = ph_ns_amber;
			ph_ns_amber:                  model_next = ph_all_red_b;
			default:                      model_next = w ? ph_ew_walk : ph_ew_green;
		endcase
	endfunction

	// phase lengths in cycles, straight from the timing table
	function automatic int model_duration(input logic [phase_width-1:0] ph);
		case (ph)
			ph_ew_walk, ph_ns_walk:           model_duration = 10;
			ph_ew_flash, ph_ns_flash:         model_duration = 20;
			ph_ew_dont_walk, ph_ns_dont_walk: model_duration = 30;
			ph_ew_green, ph_ns_green:         model_duration = 60;
			ph_ew_amber, ph_ns_amber:         model_duration = 6;
			ph_all_red_a, ph_all_red_b:       model_duration = 2;
			ph_sb_left:                       model_duration = 20;
			default:                          model_duration = 0;
		endcase
	endfunction

	// lamp map packed as nb[24:19], sb[18:12], eb[11:6], wb[5:0]
	function automatic logic [24:0] expected_lamps(input logic [phase_width-1:0] ph);
		logic ewg, ewa, eww, ewf, nsg, nsa, nsw, nsf, arrow;
		ewg = (ph == ph_ew_walk) || (ph == ph_ew_flash) ||
			(ph == ph_ew_dont_walk) || (ph == ph_ew_green);
		nsg = (ph == ph_ns_walk) || (ph == ph_ns_flash) ||
			(ph == ph_ns_dont_walk) || (ph == ph_ns_green);
		ewa = (ph == ph_ew_amber);
		nsa = (ph == ph_ns_amber);
		eww = (ph == ph_ew_walk);
		ewf = (ph == ph_ew_flash);
		nsw = (ph == ph_ns_walk);
		nsf = (ph == ph_ns_flash);
		arrow = (ph == ph_sb_left);
		expected_lamps = {nsg, nsa, !(nsg || nsa), nsw, nsf, !(nsw || nsf),
			nsg, nsa, !(nsg || nsa || arrow), arrow, nsw, nsf, !(nsw || nsf),
			ewg, ewa, !(ewg || ewa), eww, ewf, !(eww || ewf),
			ewg, ewa, !(ewg || ewa), eww, ewf, !(eww || ewf)};
	endfunction

	// 32 bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	wire [24:0] exp_lamps = expected_lamps(m_phase);
	assign m_next = model_next(m_phase, m_walk, m_left);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// model follows the DUT edge for edge, requests sampled on the same rising edge
	always @(posedge clk or posedge reset) begin
		if (reset) begin
			m_phase <= ph_ew_green;
			m_count <= 60;
			m_walk  <= 1'b0;
			m_left  <= 1'b0;
		end else begin
			if (m_count == 1) begin
				m_phase <= m_next;
				m_count <= model_duration(m_next);
			end else begin
				m_count <= m_count - 1;
			end
			m_walk <= walk_request ||
				(m_walk && !(m_count == 1 && (m_next == ph_ew_walk || m_next == ph_ns_walk)));
			m_left <= southbound_left_request || (m_left && !(m_count == 1 && m_next == ph_sb_left));
		end
	end

	task automatic check_lamps(input string name, input logic [6:0] exp, input logic [6:0] act);
		lamp_checks++;
		assert (act == exp) else begin
			lamp_errors++;
			$display("error: %0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		test_checks++;
		assert (act == exp) else begin
			test_errors++;
			$display("error: %0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	// every lamp against the model on every falling edge
	always @(negedge clk) begin
		check_lamps("northbound lamps", {1'b0, exp_lamps[24:19]}, {1'b0, nb_act});
		check_lamps("southbound lamps", exp_lamps[18:12], sb_act);
		check_lamps("eastbound lamps", {1'b0, exp_lamps[11:6]}, {1'b0, eb_act});
		check_lamps("westbound lamps", {1'b0, exp_lamps[5:0]}, {1'b0, wb_act});
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic logic lamp_on(input int sel);
		case (sel)
			sel_ew_green: lamp_on = eastbound_green;
			sel_ew_amber: lamp_on = eastbound_amber;
			sel_all_red:  lamp_on = eastbound_red && northbound_red && southbound_red;
			sel_ns_green: lamp_on = northbound_green;
			sel_ns_amber: lamp_on = northbound_amber;
			sel_ew_walk:  lamp_on = eastbound_walk;
			sel_ew_flash: lamp_on = eastbound_flashing_dont_walk;
			sel_ns_walk:  lamp_on = northbound_walk;
			sel_ns_flash: lamp_on = northbound_flashing_dont_walk;
			sel_left:     lamp_on = southbound_left;
			default:      lamp_on = 1'b0;
		endcase
	endfunction

	// waits for a lamp, then counts falling edges while it stays lit
	// returns on the first falling edge of the following phase
	task automatic measure_on(input int sel, input int expected, input string name);
		int n;
		n = 0;
		while (!lamp_on(sel)) @(negedge clk);
		while (lamp_on(sel)) begin
			n++;
			@(negedge clk);
		end
		check_count(name, expected, n);
	endtask

	// one cycle request pulse, starting on a falling edge
	task automatic pulse(input logic walk, input logic left);
		walk_request = walk;
		southbound_left_request = left;
		@(negedge clk);
		walk_request = 1'b0;
		southbound_left_request = 1'b0;
	endtask

	task automatic test_no_requests();
		measure_on(sel_ew_green, 60, "eastbound_green cycles");
		measure_on(sel_ew_amber, 6, "eastbound_amber cycles");
		measure_on(sel_all_red, 2, "all red cycles");
		measure_on(sel_ns_green, 60, "northbound_green cycles");
		measure_on(sel_ns_amber, 6, "northbound_amber cycles");
		measure_on(sel_all_red, 2, "all red cycles");
	endtask

	// pulse in ew_green serves north/south first, a second pulse in ns_amber
	// then brings the east/west walk path
	task automatic test_walk_request();
		pulse(1'b1, 1'b0);
		measure_on(sel_ew_green, 59, "eastbound_green cycles");
		measure_on(sel_ew_amber, 6, "eastbound_amber cycles");
		measure_on(sel_all_red, 2, "all red cycles");
		measure_on(sel_ns_walk, 10, "northbound_walk cycles");
		measure_on(sel_ns_flash, 20, "northbound_flashing_dont_walk cycles");
		measure_on(sel_ns_green, 30, "northbound_green cycles after flash");
		pulse(1'b1, 1'b0);
		measure_on(sel_ns_amber, 5, "northbound_amber cycles");
		measure_on(sel_all_red, 2, "all red cycles");
		measure_on(sel_ew_walk, 10, "eastbound_walk cycles");
		measure_on(sel_ew_flash, 20, "eastbound_flashing_dont_walk cycles");
		measure_on(sel_ew_green, 30, "eastbound_green cycles after flash");
		measure_on(sel_ew_amber, 6, "eastbound_amber cycles");
	endtask

	// the served walk flag is gone, both axes go back to plain green
	task automatic test_flag_clears();
		measure_on(sel_all_red, 2, "all red cycles");
		check_count("northbound_walk", 0, int'(northbound_walk));
		measure_on(sel_ns_green, 60, "northbound_green cycles");
		measure_on(sel_ns_amber, 6, "northbound_amber cycles");
		measure_on(sel_all_red, 2, "all red cycles");
		check_count("eastbound_walk", 0, int'(eastbound_walk));
		measure_on(sel_ew_green, 60, "eastbound_green cycles");
	endtask

	task automatic test_left_request();
		pulse(1'b0, 1'b1);
		measure_on(sel_ew_amber, 5, "eastbound_amber cycles");
		measure_on(sel_all_red, 2, "all red cycles");
		check_count("southbound_red", 0, int'(southbound_red));
		check_count("northbound_red", 1, int'(northbound_red));
		measure_on(sel_left, 20, "southbound_left cycles");
		check_count("northbound_walk", 0, int'(northbound_walk));
		measure_on(sel_ns_green, 60, "northbound_green cycles");
	endtask

	task automatic test_left_and_walk();
		measure_on(sel_ns_amber, 6, "northbound_amber cycles");
		measure_on(sel_all_red, 2, "all red cycles");
		pulse(1'b1, 1'b1);
		measure_on(sel_ew_green, 59, "eastbound_green cycles");
		measure_on(sel_ew_amber, 6, "eastbound_amber cycles");
		measure_on(sel_all_red, 2, "all red cycles");
		measure_on(sel_left, 20, "southbound_left cycles");
		measure_on(sel_ns_walk, 10, "northbound_walk cycles");
		measure_on(sel_ns_flash, 20, "northbound_flashing_dont_walk cycles");
		measure_on(sel_ns_green, 30, "northbound_green cycles after flash");
		measure_on(sel_ns_amber, 6, "northbound_amber cycles");
		measure_on(sel_all_red, 2, "all red cycles");
		// both flags served, next round has neither walk nor arrow
		check_count("eastbound_walk", 0, int'(eastbound_walk));
		measure_on(sel_ew_green, 60, "eastbound_green cycles");
		measure_on(sel_ew_amber, 6, "eastbound_amber cycles");
		measure_on(sel_all_red, 2, "all red cycles");
		check_count("southbound_left", 0, int'(southbound_left));
		check_count("northbound_walk", 0, int'(northbound_walk));
	endtask

	// each request fires when four fresh LFSR bits are all ones
	task automatic draw_request(output logic hit);
		hit = 1'b1;
		repeat (4) begin
			lfsr = lfsr_step(lfsr);
			hit = hit & lfsr[0];
		end
	endtask

	task automatic test_random_requests();
		logic w;
		logic l;
		repeat (3000) begin
			draw_request(w);
			draw_request(l);
			walk_request = w;
			southbound_left_request = l;
			@(negedge clk);
		end
		walk_request = 1'b0;
		southbound_left_request = 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		walk_request = 1'b0;
		southbound_left_request = 1'b0;
		lfsr = 32'h3299dd20;
		cycles = 0;
		test_checks = 0;
		test_errors = 0;
		lamp_checks = 0;
		lamp_errors = 0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		test_no_requests();
		test_walk_request();
		test_flag_clears();
		test_left_request();
		test_left_and_walk();
		test_random_requests();
		$display("directed checks %0d errors %0d, lamp checks %0d errors %0d",
			test_checks, test_errors, lamp_checks, lamp_errors);
		if (test_errors + lamp_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- compile.f
hdl/traffic_pkg.sv
hdl/phase_timer.sv
hdl/phase_sequencer.sv
hdl/signal_decoder.sv
hdl/traffic_signal_controller.sv
verif/traffic_chk.sv
verif/traffic_tb.sv

//--- Makefile
sim:
	verilator --binary --timing --assert --top-module traffic_tb -Mdir obj_dir -f compile.f
	./obj_dir/Vtraffic_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "CHECKS FAILED" sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
